// ==== common/kyber_pkg.sv ====
/*
 * Kyber parse shared definitions
 * Modulus, block geometry, coefficient and word types, FSM states
 */

package kyber_pkg;

	// --------------------------------------------------
	// Constants
	// --------------------------------------------------
	// Acceptance bound for rejection sampling
	parameter int KYBER_Q = 3329;

	// Coefficients per polynomial
	parameter int KYBER_N = 256;

	parameter int COEFF_W = 12;
	parameter int WORD_W = 64;

	// 96 words of 64 bits
	parameter int BLOCK_BYTES = 768;

	// Coefficients per output group
	parameter int GROUP_SIZE = 4;

	// --------------------------------------------------
	// Types
	// --------------------------------------------------
	typedef logic [COEFF_W-1:0] coeff_t;

	typedef logic [WORD_W-1:0] word_t;

	// Index GROUP_SIZE-1 is the first coefficient, top bits
	typedef coeff_t [GROUP_SIZE-1:0] group_t;

	// Block FSM
	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		SAMPLE,
		DONE
	} parse_state_e;

endpackage

// ==== common/sample_if.sv ====
/*
 * Sampler to packer bundle
 * Four candidates of one step with their accept flags
 */

`timescale 1ns/10ps

interface sample_if;
	import kyber_pkg::*;

	// Index 0 first: d1, d2 of triple 0, then d1, d2 of triple 1
	coeff_t [3:0] cand;
	logic [3:0] accept;
	logic valid;

	modport src (
		output cand,
		output accept,
		output valid
	);

	modport dst (
		input cand,
		input accept,
		input valid
	);

endinterface

// ==== hw/parse/parse_ctrl.sv ====
/*
 * Parse block controller
 * Word capture, sampling step sequencing, done and clear pulses
 */

`timescale 1ns/10ps

module parse_ctrl #(
	parameter int BLOCK_WORDS = 96
) (
	input  logic i_clk,
	input  logic i_rstn,
	input  logic i_ibytes_valid,
	input  logic i_full,
	output logic o_wr_en,
	output logic [$clog2(BLOCK_WORDS)-1:0] o_wr_idx,
	// Six bytes (48 bits) per step
	output logic [$clog2(BLOCK_WORDS * kyber_pkg::WORD_W / 48)-1:0] o_step,
	output logic o_sampling,
	output logic o_clear,
	output logic o_done
);
	import kyber_pkg::*;

	localparam int STEPS = BLOCK_WORDS * WORD_W / 48;
	localparam int WIDX_W = $clog2(BLOCK_WORDS);
	localparam int STEP_W = $clog2(STEPS);

	parse_state_e state;
	parse_state_e state_nxt;
	logic [WIDX_W-1:0] word_cnt;
	logic [STEP_W-1:0] step_cnt;
	logic last_word;
	logic last_step;
	logic drain;

	// --------------------------------------------------
	// FSM
	// --------------------------------------------------
	assign o_wr_en = ((state == IDLE) || (state == LOAD)) && i_ibytes_valid;
	assign last_word = (word_cnt == WIDX_W'(BLOCK_WORDS - 1));
	assign last_step = (step_cnt == STEP_W'(STEPS - 1));

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE, LOAD: begin
				if (o_wr_en) begin
					state_nxt = last_word ? SAMPLE : LOAD;
				end
			end
			// Drain cycle lets the last group leave before done
			SAMPLE: begin
				if (drain || i_full) begin
					state_nxt = DONE;
				end
			end
			DONE: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	// --------------------------------------------------
	// State and counters
	// --------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			state <= IDLE;
			word_cnt <= '0;
			step_cnt <= '0;
			drain <= 1'b0;
		end else begin
			state <= state_nxt;
			if (o_wr_en) begin
				word_cnt <= last_word ? '0 : word_cnt + 1'b1;
			end
			if (o_sampling) begin
				step_cnt <= step_cnt + 1'b1;
				if (last_step) begin
					drain <= 1'b1;
				end
			end
			if (state == DONE) begin
				step_cnt <= '0;
				drain <= 1'b0;
			end
		end
	end

	assign o_wr_idx = word_cnt;
	assign o_step = step_cnt;
	assign o_sampling = (state == SAMPLE) && !drain;
	assign o_clear = (state == DONE);
	assign o_done = (state == DONE);

endmodule

// ==== hw/parse/byte_buffer.sv ====
/*
 * Block byte store
 * Written one word per cycle, read six bytes per sampling step
 */

`timescale 1ns/10ps

module byte_buffer #(
	parameter int BLOCK_WORDS = 96
) (
	input  logic i_clk,
	input  logic i_wr_en,
	input  logic [$clog2(BLOCK_WORDS)-1:0] i_wr_idx,
	input  kyber_pkg::word_t i_word,
	input  logic [$clog2(BLOCK_WORDS * kyber_pkg::WORD_W / 48)-1:0] i_step,
	output logic [5:0][7:0] o_bytes
);
	import kyber_pkg::*;

	localparam int WORD_BYTES = WORD_W / 8;
	localparam int NBYTES = BLOCK_WORDS * WORD_BYTES;
	localparam int ADDR_W = $clog2(NBYTES);
	localparam int STEP_BYTES = 6;

	logic [7:0] mem [NBYTES];
	logic [ADDR_W-1:0] wr_base;
	logic [ADDR_W-1:0] rd_base;

	assign wr_base = ADDR_W'(i_wr_idx) * ADDR_W'(WORD_BYTES);
	assign rd_base = ADDR_W'(i_step) * ADDR_W'(STEP_BYTES);

	// MSB of a word is the earliest byte in the stream
	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			for (int j = 0; j < WORD_BYTES; j++) begin
				mem[wr_base + ADDR_W'(j)] <= i_word[WORD_W-1-8*j -: 8];
			end
		end
	end

	// Step window may cross a word boundary
	always_comb begin
		for (int k = 0; k < STEP_BYTES; k++) begin
			o_bytes[k] = mem[rd_base + ADDR_W'(k)];
		end
	end

endmodule

// ==== hw/parse/rej_sampler.sv ====
/*
 * Rejection sampler
 * Two byte triples to four 12-bit candidates, each tested against q
 */

`timescale 1ns/10ps

module rej_sampler (
	input  logic [5:0][7:0] i_bytes,
	input  logic i_en,
	sample_if.src sif
);
	import kyber_pkg::*;

	coeff_t [3:0] cand;
	logic [3:0] accept;

	// --------------------------------------------------
	// Candidate extraction
	// --------------------------------------------------
	for (genvar t = 0; t < 2; t++) begin : g_triple
		// d1 = b0 + 256 * (b1 mod 16)
		assign cand[2*t] = {i_bytes[3*t+1][3:0], i_bytes[3*t]};
		// d2 = (b1 >> 4) + 16 * b2
		assign cand[2*t+1] = {i_bytes[3*t+2], i_bytes[3*t+1][7:4]};
	end

	for (genvar k = 0; k < 4; k++) begin : g_accept
		assign accept[k] = (cand[k] < coeff_t'(KYBER_Q));
	end

	assign sif.cand = cand;
	assign sif.accept = accept;
	assign sif.valid = i_en;

endmodule

// ==== hw/parse/coeff_packer.sv ====
/*
 * Coefficient packer
 * Compacts accepted candidates in order, emits groups of four
 * and stops at the group limit
 */

`timescale 1ns/10ps

module coeff_packer #(
	parameter int MAX_GROUPS = 64
) (
	input  logic i_clk,
	input  logic i_rstn,
	input  logic i_clear,
	sample_if.dst sif,
	output kyber_pkg::group_t o_coeffs,
	output logic o_coeffs_valid,
	output logic o_full
);
	import kyber_pkg::*;

	localparam int CANDS = 4;
	localparam int HOLD = GROUP_SIZE - 1;
	localparam int STAGE = HOLD + CANDS;
	localparam int FILL_W = $clog2(STAGE + 1);
	localparam int CNT_W = $clog2(MAX_GROUPS + 1);

	coeff_t held [HOLD];
	logic [FILL_W-1:0] held_cnt;
	coeff_t stage [STAGE];
	logic [FILL_W-1:0] fill;
	logic [CNT_W-1:0] grp_cnt;
	logic limit_hit;
	logic take;
	logic emit;

	assign limit_hit = (grp_cnt == CNT_W'(MAX_GROUPS));
	assign take = sif.valid && !limit_hit;
	assign emit = (fill >= FILL_W'(GROUP_SIZE)) && !limit_hit;

	// --------------------------------------------------
	// Staging: leftovers first, then this step's accepts
	// --------------------------------------------------
	always_comb begin
		for (int i = 0; i < STAGE; i++) begin
			stage[i] = '0;
		end
		for (int i = 0; i < HOLD; i++) begin
			stage[i] = held[i];
		end
		fill = held_cnt;
		for (int k = 0; k < CANDS; k++) begin
			if (take && sif.accept[k]) begin
				stage[fill] = sif.cand[k];
				fill = fill + 1'b1;
			end
		end
	end

	// Leftovers shift down by a group when one goes out
	always_ff @(posedge i_clk) begin
		for (int i = 0; i < HOLD; i++) begin
			held[i] <= emit ? stage[i + GROUP_SIZE] : stage[i];
		end
	end

	// --------------------------------------------------
	// Group output and limit count
	// --------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			held_cnt <= '0;
			grp_cnt <= '0;
			o_coeffs_valid <= 1'b0;
			o_coeffs <= '0;
		end else if (i_clear) begin
			held_cnt <= '0;
			grp_cnt <= '0;
			o_coeffs_valid <= 1'b0;
		end else begin
			o_coeffs_valid <= emit;
			if (emit) begin
				// Oldest value to the top slot
				for (int g = 0; g < GROUP_SIZE; g++) begin
					o_coeffs[GROUP_SIZE-1-g] <= stage[g];
				end
				grp_cnt <= grp_cnt + 1'b1;
				held_cnt <= fill - FILL_W'(GROUP_SIZE);
			end else begin
				held_cnt <= fill;
			end
		end
	end

	assign o_full = limit_hit;

endmodule

// ==== hw/parse_top.sv ====
/*
 * Kyber parse top level
 * Uniform rejection sampling of one 768-byte block into 256 coefficients
 */

`timescale 1ns/10ps

module parse_top #(
	parameter int BLOCK_WORDS = kyber_pkg::BLOCK_BYTES * 8 / kyber_pkg::WORD_W,
	parameter int MAX_GROUPS = kyber_pkg::KYBER_N / kyber_pkg::GROUP_SIZE
) (
	input  logic i_clk,
	input  logic i_rstn,
	input  kyber_pkg::word_t i_ibytes,
	input  logic i_ibytes_valid,
	output kyber_pkg::group_t o_coeffs,
	output logic o_coeffs_valid,
	output logic o_done
);
	import kyber_pkg::*;

	localparam int WIDX_W = $clog2(BLOCK_WORDS);
	localparam int STEP_W = $clog2(BLOCK_WORDS * WORD_W / 48);

	logic wr_en;
	logic [WIDX_W-1:0] wr_idx;
	logic [STEP_W-1:0] step;
	logic sampling;
	logic clear;
	logic full;
	logic [5:0][7:0] step_bytes;

	sample_if u_sif ();

	parse_ctrl #(
		.BLOCK_WORDS (BLOCK_WORDS)
	) u_ctrl (
		.i_clk          (i_clk),
		.i_rstn         (i_rstn),
		.i_ibytes_valid (i_ibytes_valid),
		.i_full         (full),
		.o_wr_en        (wr_en),
		.o_wr_idx       (wr_idx),
		.o_step         (step),
		.o_sampling     (sampling),
		.o_clear        (clear),
		.o_done         (o_done)
	);

	byte_buffer #(
		.BLOCK_WORDS (BLOCK_WORDS)
	) u_buf (
		.i_clk    (i_clk),
		.i_wr_en  (wr_en),
		.i_wr_idx (wr_idx),
		.i_word   (i_ibytes),
		.i_step   (step),
		.o_bytes  (step_bytes)
	);

	rej_sampler u_rej (
		.i_bytes (step_bytes),
		.i_en    (sampling),
		.sif     (u_sif)
	);

	coeff_packer #(
		.MAX_GROUPS (MAX_GROUPS)
	) u_pack (
		.i_clk          (i_clk),
		.i_rstn         (i_rstn),
		.i_clear        (clear),
		.sif            (u_sif),
		.o_coeffs       (o_coeffs),
		.o_coeffs_valid (o_coeffs_valid),
		.o_full         (full)
	);

endmodule

// ==== testbench/tb_parse.sv ====
/*
 * Testbench for the Kyber parse top level
 * Random blocks checked against a rejection sampling model
 */

`timescale 1ns/10ps

module tb_parse;
	import kyber_pkg::*;

	localparam int BLOCK_WORDS = BLOCK_BYTES * 8 / WORD_W;
	localparam int TRIPLES = BLOCK_BYTES / 3;
	localparam int NUM_BLOCKS = 7;
	localparam int MAX_GAP = 3;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT = NUM_BLOCKS * (BLOCK_WORDS + BLOCK_WORDS * MAX_GAP + 128 + 8)
		+ RESET_CYCLES;

	localparam int MODE_UNIFORM = 0;
	localparam int MODE_REJECT = 1;
	localparam int MODE_BOUNDARY = 2;

	logic i_clk;
	logic i_rstn;
	word_t i_ibytes;
	logic i_ibytes_valid;
	group_t o_coeffs;
	logic o_coeffs_valid;
	logic o_done;

	integer seed;
	logic [7:0] blk [BLOCK_BYTES];
	group_t exp_q [$];
	int exp_groups;
	int blk_groups;
	int seen_3328;
	int cycle_cnt;
	bit quiet;
	bit done_seen;
	bit any_group;

	parse_top dut0 (
		.i_clk          (i_clk),
		.i_rstn         (i_rstn),
		.i_ibytes       (i_ibytes),
		.i_ibytes_valid (i_ibytes_valid),
		.o_coeffs       (o_coeffs),
		.o_coeffs_valid (o_coeffs_valid),
		.o_done         (o_done)
	);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	// --------------------------------------------------
	// Failure reporting and compare tasks
	// --------------------------------------------------
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_group(input string name, input group_t act, input group_t exp);
		if (act !== exp) begin
			$display("Fail t=%0t %s got %h expected %h", $time, name, act, exp);
			abort_run("Group mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			$display("Fail t=%0t %s got %b expected %b", $time, name, act, exp);
			abort_run("Control bit mismatch");
		end
	endtask

	task automatic check_count(input string name, input int act, input int exp);
		if (act != exp) begin
			$display("Fail t=%0t %s got %0d expected %0d", $time, name, act, exp);
			abort_run("Count mismatch");
		end
	endtask

	// --------------------------------------------------
	// Block generation and reference model
	// --------------------------------------------------
	task automatic build_block(input int mode);
		logic [31:0] rnd;
		for (int t = 0; t < TRIPLES; t++) begin
			rnd = $random(seed);
			blk[3*t] = rnd[7:0];
			blk[3*t+1] = rnd[15:8];
			blk[3*t+2] = rnd[23:16];
			if (mode == MODE_REJECT && rnd[26:24] != 3'd0) begin
				// Low nibble 14 or 15 and b2 from the top
				blk[3*t+1] = {4'hf, 3'b111, rnd[27]};
				blk[3*t+2] = {3'b111, rnd[20:16]};
			end else if (mode == MODE_BOUNDARY) begin
				case (t % 4)
					// 3328 then 3329
					0: begin
						blk[3*t] = 8'h00;
						blk[3*t+1] = 8'h1d;
						blk[3*t+2] = 8'hd0;
					end
					// 3329 then 3328
					1: begin
						blk[3*t] = 8'h01;
						blk[3*t+1] = 8'h0d;
						blk[3*t+2] = 8'hd0;
					end
					// 4095 twice
					2: begin
						blk[3*t] = 8'hff;
						blk[3*t+1] = 8'hff;
						blk[3*t+2] = 8'hff;
					end
					default: ;
				endcase
			end
		end
	endtask

	task automatic expect_block();
		int acc [$];
		int d1;
		int d2;
		group_t grp;
		for (int t = 0; t < TRIPLES; t++) begin
			d1 = int'(blk[3*t]) + 256 * int'(blk[3*t+1][3:0]);
			d2 = int'(blk[3*t+1][7:4]) + 16 * int'(blk[3*t+2]);
			if (d1 < KYBER_Q && acc.size() < KYBER_N) begin
				acc.push_back(d1);
			end
			if (d2 < KYBER_Q && acc.size() < KYBER_N) begin
				acc.push_back(d2);
			end
		end
		// Leftover partial group is dropped
		exp_groups = acc.size() / GROUP_SIZE;
		for (int g = 0; g < exp_groups; g++) begin
			for (int i = 0; i < GROUP_SIZE; i++) begin
				grp[GROUP_SIZE-1-i] = coeff_t'(acc[GROUP_SIZE*g+i]);
			end
			exp_q.push_back(grp);
		end
	endtask

	// --------------------------------------------------
	// Stimulus for one block
	// --------------------------------------------------
	task automatic run_block(input int mode, input int max_gap, input bit junk_on);
		word_t wrd;
		logic [31:0] rnd;
		int gap;
		build_block(mode);
		expect_block();
		done_seen = 1'b0;
		for (int w = 0; w < BLOCK_WORDS; w++) begin
			rnd = $random(seed);
			gap = (max_gap > 0) ? int'(rnd[7:0]) % (max_gap + 1) : 0;
			repeat (gap) begin
				@(posedge i_clk);
				i_ibytes <= {$random(seed), $random(seed)};
				i_ibytes_valid <= 1'b0;
			end
			// First byte of the stream in the top bits
			for (int j = 0; j < WORD_W / 8; j++) begin
				wrd[WORD_W-1-8*j -: 8] = blk[8*w+j];
			end
			@(posedge i_clk);
			i_ibytes <= wrd;
			i_ibytes_valid <= 1'b1;
		end
		quiet = 1'b0;
		// Words offered while sampling must be ignored
		while (!done_seen) begin
			@(posedge i_clk);
			if (done_seen) begin
				i_ibytes_valid <= 1'b0;
			end else begin
				rnd = $random(seed);
				i_ibytes <= {$random(seed), $random(seed)};
				i_ibytes_valid <= junk_on & rnd[0];
			end
		end
	endtask

	// --------------------------------------------------
	// Output monitor, sampled mid-cycle
	// --------------------------------------------------
	always @(negedge i_clk) begin
		if (i_rstn) begin
			if (quiet) begin
				check_bit("o_coeffs_valid", o_coeffs_valid, 1'b0);
				check_bit("o_done", o_done, 1'b0);
				if (!any_group) begin
					check_group("o_coeffs", o_coeffs, group_t'('0));
				end
			end else begin
				if (o_coeffs_valid) begin
					if (exp_q.size() == 0) begin
						abort_run("o_coeffs_valid high with no group expected");
					end
					check_group("o_coeffs", o_coeffs, exp_q.pop_front());
					for (int i = 0; i < GROUP_SIZE; i++) begin
						if (o_coeffs[i] == coeff_t'(KYBER_Q - 1)) begin
							seen_3328++;
						end
					end
					blk_groups++;
					any_group = 1'b1;
				end
				if (o_done) begin
					check_bit("o_coeffs_valid", o_coeffs_valid, 1'b0);
					check_count("groups per block", blk_groups, exp_groups);
					blk_groups = 0;
					quiet = 1'b1;
					done_seen = 1'b1;
				end
			end
		end
	end

	always @(posedge i_clk) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT) begin
			abort_run("Timeout: the run did not finish within the cycle limit");
		end
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial begin
		seed = 32'h724a;
		i_rstn = 1'b0;
		i_ibytes = '0;
		i_ibytes_valid = 1'b0;
		quiet = 1'b1;
		done_seen = 1'b0;
		any_group = 1'b0;
		blk_groups = 0;
		exp_groups = 0;
		seen_3328 = 0;
		cycle_cnt = 0;
		repeat (3) @(posedge i_clk);
		i_rstn <= 1'b1;
		// Idle cycles checked by the monitor
		repeat (4) @(posedge i_clk);

		run_block(MODE_UNIFORM, MAX_GAP, 1'b0);
		run_block(MODE_REJECT, 2, 1'b1);
		run_block(MODE_BOUNDARY, 1, 1'b1);
		// Back to back, no gaps
		run_block(MODE_UNIFORM, 0, 1'b1);
		run_block(MODE_UNIFORM, 0, 1'b1);
		run_block(MODE_REJECT, 0, 1'b1);
		run_block(MODE_UNIFORM, MAX_GAP, 1'b1);

		@(posedge i_clk);
		// Largest accepted value must reach the output
		check_bit("coefficient 3328 seen", seen_3328 > 0, 1'b1);
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== sources.f ====
common/kyber_pkg.sv
common/sample_if.sv
hw/parse/parse_ctrl.sv
hw/parse/byte_buffer.sv
hw/parse/rej_sampler.sv
hw/parse/coeff_packer.sv
hw/parse_top.sv
testbench/tb_parse.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing -j 0 -Wno-fatal
TOP = tb_parse
FILELIST = sources.f
OBJ_DIR = obj_dir

BIN = $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
